/* hw/sdram_params.svh */
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// Power-up wait, 200 us at 50 MHz
`define SDRAM_INIT_WAIT 14'd10000

// Auto-refreshes issued during power-up
`define SDRAM_INIT_REFRESHES 4'd8

// Refresh to next command, in cycles
`define SDRAM_TRC 3'd6

// 64 ms / 8192 rows / 20 ns
`define SDRAM_REFRESH_INTERVAL 9'd390

// Read data appears this many cycles after READ
`define SDRAM_CAS_LATENCY 2'd3

// Burst length 1, sequential, CL 3, burst write
`define SDRAM_MODE_WORD 12'h030

`endif

/* hw/sdram_pkg.sv */
package sdram_pkg;

	// Bus word address {bank, row, column}
	typedef logic [21:0] avl_addr_t;
	typedef logic [15:0] data_t;
	typedef logic [1:0]  byte_en_t;

	// Address fields, row width is also the SDRAM address bus width
	typedef logic [1:0]  bank_t;
	typedef logic [11:0] row_t;
	typedef logic [7:0]  col_t;

	// Encoded as {CSn, RASn, CASn, WEn}
	typedef enum logic [3:0] {
		CMD_NOP   = 4'b1111,
		CMD_ACT   = 4'b0011,
		CMD_READ  = 4'b0101,
		CMD_WRITE = 4'b0100,
		CMD_PALL  = 4'b0010,
		CMD_REF   = 4'b0001,
		CMD_MRS   = 4'b0000
	} sdram_cmd_t;

	// Access sequencer states
	typedef enum logic [3:0] {
		ST_INIT, ST_IDLE, ST_ACT, ST_TRCD, ST_WRITE,
		ST_READ, ST_XFER_NOP, ST_DONE, ST_REF, ST_REF_NOP
	} access_state_t;

endpackage

/* hw/sdram_init_seq.sv */
`timescale 1ns/10ps
`include "sdram_params.svh"

module sdram_init_seq (
	input  logic                  sys_clk,
	input  logic                  rstn,
	output sdram_pkg::sdram_cmd_t init_cmd,
	output sdram_pkg::row_t       init_addr,
	output logic                  init_done
);

	// Power-up phases
	typedef enum logic [2:0] {
		PH_WAIT, PH_PALL, PH_NOP, PH_REF, PH_MRS, PH_DONE
	} phase_t;

	phase_t      phase;
	// Shared by the 200 us wait and the NOP spacing
	logic [13:0] wait_cnt;
	// Refreshes issued so far
	logic [3:0]  ref_cnt;
	logic [13:0] nop_last;
	logic        wait_over;
	logic        nop_over;

	// One NOP after PALL, tRC - 1 NOPs after each REF
	assign nop_last  = (ref_cnt == 4'd0) ? 14'd0 : {11'd0, `SDRAM_TRC} - 14'd2;
	assign wait_over = (wait_cnt == `SDRAM_INIT_WAIT - 14'd1);
	assign nop_over  = (wait_cnt == nop_last);

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			phase    <= PH_WAIT;
			wait_cnt <= 14'd0;
			ref_cnt  <= 4'd0;
		end else begin
			case (phase)
				PH_WAIT: begin
					if (wait_over) begin
						wait_cnt <= 14'd0;
						phase    <= PH_PALL;
					end else begin
						wait_cnt <= wait_cnt + 14'd1;
					end
				end
				PH_PALL: phase <= PH_NOP;
				PH_NOP: begin
					if (nop_over) begin
						wait_cnt <= 14'd0;
						// Mode set once all refreshes are out
						phase <= (ref_cnt == `SDRAM_INIT_REFRESHES) ? PH_MRS : PH_REF;
					end else begin
						wait_cnt <= wait_cnt + 14'd1;
					end
				end
				PH_REF: begin
					ref_cnt <= ref_cnt + 4'd1;
					phase   <= PH_NOP;
				end
				PH_MRS: phase <= PH_DONE;
				// Parked here for good
				default: phase <= PH_DONE;
			endcase
		end
	end

	// Command and address decode
	always_comb begin
		init_cmd  = sdram_pkg::CMD_NOP;
		init_addr = 12'h000;
		case (phase)
			PH_PALL: begin
				init_cmd  = sdram_pkg::CMD_PALL;
				// A10 high, all banks
				init_addr = 12'h400;
			end
			PH_REF: init_cmd = sdram_pkg::CMD_REF;
			PH_MRS: begin
				init_cmd  = sdram_pkg::CMD_MRS;
				init_addr = `SDRAM_MODE_WORD;
			end
			default: init_cmd = sdram_pkg::CMD_NOP;
		endcase
	end

	// High from the cycle after MRS
	assign init_done = (phase == PH_DONE);

	// Sequence runs once per reset
	a_done_sticky: assert property (@(posedge sys_clk) disable iff (!rstn)
		init_done |=> init_done);

endmodule

/* hw/sdram_refresh_timer.sv */
`timescale 1ns/10ps
`include "sdram_params.svh"

module sdram_refresh_timer (
	input  logic sys_clk,
	input  logic rstn,
	input  logic refresh_start,
	output logic refresh_due
);

	// Cycles since the last refresh command
	logic [8:0] ref_cnt;
	logic       cnt_full;

	// Saturates at the interval instead of wrapping
	assign cnt_full = (ref_cnt == `SDRAM_REFRESH_INTERVAL);

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			ref_cnt <= 9'd0;
		end else if (refresh_start) begin
			// Restart on every issued REF
			ref_cnt <= 9'd0;
		end else if (!cnt_full) begin
			ref_cnt <= ref_cnt + 9'd1;
		end
	end

	// Held until the sequencer answers with a REF
	assign refresh_due = cnt_full;

	// Sequencer only refreshes on demand
	a_start_when_due: assert property (@(posedge sys_clk) disable iff (!rstn)
		refresh_start |-> refresh_due);

endmodule

/* hw/sdram_access_ctrl.sv */
`timescale 1ns/10ps
`include "sdram_params.svh"

module sdram_access_ctrl (
	input  logic                  sys_clk,
	input  logic                  rstn,
	input  sdram_pkg::sdram_cmd_t init_cmd,
	input  sdram_pkg::row_t       init_addr,
	input  logic                  init_done,
	input  logic                  refresh_due,
	output logic                  refresh_start,
	input  sdram_pkg::avl_addr_t  avl_addr,
	input  sdram_pkg::byte_en_t   avl_byte_en,
	input  logic                  avl_write,
	input  logic                  avl_read,
	input  sdram_pkg::data_t      avl_wrdata,
	output sdram_pkg::data_t      avl_rddata,
	output logic                  avl_req_wait,
	output logic                  csn,
	output logic                  rasn,
	output logic                  casn,
	output logic                  wen,
	output sdram_pkg::bank_t      ba,
	output sdram_pkg::row_t       addr,
	output sdram_pkg::byte_en_t   dqm,
	output sdram_pkg::data_t      dq_out,
	output logic                  dq_oe,
	input  sdram_pkg::data_t      dq_in
);

	// Five NOPs after WRITE for write recovery and auto-precharge
	localparam logic [2:0] WR_LAST  = 3'd4;
	// Last NOP after READ is where data lands
	localparam logic [2:0] RD_LAST  = {1'b0, `SDRAM_CAS_LATENCY} - 3'd1;
	localparam logic [2:0] REF_LAST = `SDRAM_TRC - 3'd2;

	sdram_pkg::access_state_t state;
	sdram_pkg::sdram_cmd_t    cmd;
	logic [2:0]               nop_cnt;
	logic                     req_write;
	logic                     accept;
	logic                     capture;
	// Registered request
	sdram_pkg::avl_addr_t     req_addr;
	sdram_pkg::byte_en_t      req_be;
	sdram_pkg::data_t         req_data;
	sdram_pkg::data_t         rd_data;
	sdram_pkg::bank_t         req_bank;
	sdram_pkg::row_t          req_row;
	sdram_pkg::col_t          req_col;

	// Address layout {bank, row, column}
	assign req_bank = req_addr[21:20];
	assign req_row  = req_addr[19:8];
	assign req_col  = req_addr[7:0];

	// Refresh wins, both strobes high is ignored
	assign accept = (state == sdram_pkg::ST_IDLE) && !refresh_due && (avl_write ^ avl_read);

	// Third cycle after READ
	assign capture = (state == sdram_pkg::ST_XFER_NOP) && !req_write && (nop_cnt == 3'd0);

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			state     <= sdram_pkg::ST_INIT;
			nop_cnt   <= 3'd0;
			req_write <= 1'b0;
		end else begin
			case (state)
				sdram_pkg::ST_INIT: begin
					if (init_done)
						state <= sdram_pkg::ST_IDLE;
				end
				sdram_pkg::ST_IDLE: begin
					if (refresh_due) begin
						state <= sdram_pkg::ST_REF;
					end else if (accept) begin
						req_write <= avl_write;
						state     <= sdram_pkg::ST_ACT;
					end
				end
				sdram_pkg::ST_ACT:  state <= sdram_pkg::ST_TRCD;
				sdram_pkg::ST_TRCD: begin
					state <= req_write ? sdram_pkg::ST_WRITE : sdram_pkg::ST_READ;
				end
				sdram_pkg::ST_WRITE: begin
					nop_cnt <= WR_LAST;
					state   <= sdram_pkg::ST_XFER_NOP;
				end
				sdram_pkg::ST_READ: begin
					nop_cnt <= RD_LAST;
					state   <= sdram_pkg::ST_XFER_NOP;
				end
				sdram_pkg::ST_XFER_NOP: begin
					if (nop_cnt == 3'd0)
						state <= sdram_pkg::ST_DONE;
					else
						nop_cnt <= nop_cnt - 3'd1;
				end
				sdram_pkg::ST_REF: begin
					nop_cnt <= REF_LAST;
					state   <= sdram_pkg::ST_REF_NOP;
				end
				sdram_pkg::ST_REF_NOP: begin
					if (nop_cnt == 3'd0)
						state <= sdram_pkg::ST_IDLE;
					else
						nop_cnt <= nop_cnt - 3'd1;
				end
				default: state <= sdram_pkg::ST_IDLE;
			endcase
		end
	end

	// Request payload, loaded on accept
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			req_addr <= avl_addr;
			req_be   <= avl_byte_en;
			req_data <= avl_wrdata;
		end
	end

	// Read word kept until the next read
	always_ff @(posedge sys_clk) begin
		if (capture)
			rd_data <= dq_in;
	end

	// Pin decode, init sequencer owns the bus until init_done
	always_comb begin
		cmd  = sdram_pkg::CMD_NOP;
		ba   = 2'b00;
		addr = 12'h000;
		dqm  = 2'b00;
		case (state)
			sdram_pkg::ST_INIT: begin
				cmd  = init_cmd;
				addr = init_addr;
				dqm  = 2'b11;
			end
			sdram_pkg::ST_ACT: begin
				cmd  = sdram_pkg::CMD_ACT;
				ba   = req_bank;
				addr = req_row;
			end
			sdram_pkg::ST_WRITE: begin
				cmd  = sdram_pkg::CMD_WRITE;
				ba   = req_bank;
				// A10 set for auto-precharge
				addr = {4'b0100, req_col};
				dqm  = ~req_be;
			end
			sdram_pkg::ST_READ: begin
				cmd  = sdram_pkg::CMD_READ;
				ba   = req_bank;
				addr = {4'b0100, req_col};
			end
			sdram_pkg::ST_REF: cmd = sdram_pkg::CMD_REF;
			default: cmd = sdram_pkg::CMD_NOP;
		endcase
	end

	assign {csn, rasn, casn, wen} = cmd;

	// Restarts the refresh interval
	assign refresh_start = (state == sdram_pkg::ST_REF);

	// Data driven around the WRITE cycle
	assign dq_out = req_data;
	assign dq_oe  = (req_write && (state == sdram_pkg::ST_TRCD))
		|| (state == sdram_pkg::ST_WRITE)
		|| (req_write && (state == sdram_pkg::ST_XFER_NOP) && (nop_cnt == WR_LAST));

	assign avl_rddata   = rd_data;
	assign avl_req_wait = (state != sdram_pkg::ST_DONE);

	// No bus contention from READ through capture
	a_no_oe_on_read: assert property (@(posedge sys_clk) disable iff (!rstn)
		(cmd == sdram_pkg::CMD_READ) |-> (!dq_oe) [*(`SDRAM_CAS_LATENCY + 1)]);

	// One-cycle release, only for a held request
	a_wait_pulse: assert property (@(posedge sys_clk) disable iff (!rstn)
		!avl_req_wait |-> (avl_write ^ avl_read) ##1 avl_req_wait);

endmodule

/* hw/sdram_controller.sv */
`timescale 1ns/10ps

module sdram_controller (
	input  logic                 sys_clk,
	input  logic                 rstn,
	input  sdram_pkg::avl_addr_t avl_addr,
	input  sdram_pkg::byte_en_t  avl_byte_en,
	input  logic                 avl_write,
	input  logic                 avl_read,
	input  sdram_pkg::data_t     avl_wrdata,
	output sdram_pkg::data_t     avl_rddata,
	output logic                 avl_req_wait,
	output logic                 csn,
	output logic                 rasn,
	output logic                 casn,
	output logic                 wen,
	output sdram_pkg::bank_t     ba,
	output sdram_pkg::row_t      addr,
	output sdram_pkg::byte_en_t  dqm,
	output sdram_pkg::data_t     dq_out,
	output logic                 dq_oe,
	input  sdram_pkg::data_t     dq_in
);

	// Power-up command stream
	sdram_pkg::sdram_cmd_t init_cmd;
	sdram_pkg::row_t       init_addr;
	logic                  init_done;
	// Refresh handshake
	logic                  refresh_due;
	logic                  refresh_start;

	sdram_init_seq u_init_seq (
		.sys_clk   (sys_clk),
		.rstn      (rstn),
		.init_cmd  (init_cmd),
		.init_addr (init_addr),
		.init_done (init_done)
	);

	sdram_refresh_timer u_refresh_timer (
		.sys_clk       (sys_clk),
		.rstn          (rstn),
		.refresh_start (refresh_start),
		.refresh_due   (refresh_due)
	);

	// Owns the SDRAM pins and the bus response
	sdram_access_ctrl u_access_ctrl (
		.sys_clk       (sys_clk),
		.rstn          (rstn),
		.init_cmd      (init_cmd),
		.init_addr     (init_addr),
		.init_done     (init_done),
		.refresh_due   (refresh_due),
		.refresh_start (refresh_start),
		.avl_addr      (avl_addr),
		.avl_byte_en   (avl_byte_en),
		.avl_write     (avl_write),
		.avl_read      (avl_read),
		.avl_wrdata    (avl_wrdata),
		.avl_rddata    (avl_rddata),
		.avl_req_wait  (avl_req_wait),
		.csn           (csn),
		.rasn          (rasn),
		.casn          (casn),
		.wen           (wen),
		.ba            (ba),
		.addr          (addr),
		.dqm           (dqm),
		.dq_out        (dq_out),
		.dq_oe         (dq_oe),
		.dq_in         (dq_in)
	);

endmodule

/* sim/sdram_model.sv */
`timescale 1ns/10ps
`include "sdram_params.svh"

module sdram_model (
	input  logic                sys_clk,
	input  logic                csn,
	input  logic                rasn,
	input  logic                casn,
	input  logic                wen,
	input  sdram_pkg::bank_t    ba,
	input  sdram_pkg::row_t     addr,
	input  sdram_pkg::byte_en_t dqm,
	input  sdram_pkg::data_t    dq_out,
	input  logic                dq_oe,
	output sdram_pkg::data_t    dq_in,
	output int                  err_count
);

	localparam int CL = `SDRAM_CAS_LATENCY;

	// Sparse array, key is {bank, row, column}
	sdram_pkg::data_t      mem [sdram_pkg::avl_addr_t];
	sdram_pkg::row_t       open_row [4];
	logic [3:0]            bank_open = 4'b0000;
	logic                  mode_set = 1'b0;
	// Read data on its way out, one stage per cycle of CAS latency
	sdram_pkg::data_t      rd_pipe [CL];
	logic [CL-1:0]         rd_valid = '0;
	sdram_pkg::sdram_cmd_t cmd;
	int                    errs = 0;

	assign cmd       = sdram_pkg::sdram_cmd_t'({csn, rasn, casn, wen});
	assign dq_in     = rd_valid[CL-1] ? rd_pipe[CL-1] : 16'h0000;
	assign err_count = errs;

	// Unwritten words, mixes every address bit
	function automatic sdram_pkg::data_t fill_word(input sdram_pkg::avl_addr_t a);
		return a[15:0] ^ {a[21:16], a[21:12]};
	endfunction

	task automatic report_violation(input string msg);
		errs++;
		$display("SDRAM model protocol error at %0t: %s", $time, msg);
	endtask

	always @(posedge sys_clk) begin
		sdram_pkg::avl_addr_t key;
		sdram_pkg::data_t     word;
		key = {ba, open_row[ba], addr[7:0]};
		rd_valid <= {rd_valid[CL-2:0], 1'b0};
		for (int i = 1; i < CL; i++)
			rd_pipe[i] <= rd_pipe[i-1];
		// Controller samples dq_in on this edge
		if (rd_valid[CL-1] && dq_oe)
			report_violation("read data returned while dq_oe is high");
		case (cmd)
			sdram_pkg::CMD_ACT: begin
				if (!mode_set)
					report_violation("ACT before the mode register was set");
				if (bank_open[ba]) begin
					report_violation("ACT to a bank that is already open");
				end else begin
					bank_open[ba] = 1'b1;
					open_row[ba]  = addr;
				end
			end
			sdram_pkg::CMD_WRITE: begin
				if (!bank_open[ba])
					report_violation("WRITE to a closed bank");
				if (!dq_oe)
					report_violation("WRITE without write data driven");
				word = mem.exists(key) ? mem[key] : fill_word(key);
				// DQM high masks the byte
				if (!dqm[0])
					word[7:0] = dq_out[7:0];
				if (!dqm[1])
					word[15:8] = dq_out[15:8];
				mem[key] = word;
				if (addr[10])
					bank_open[ba] = 1'b0;
			end
			sdram_pkg::CMD_READ: begin
				if (!bank_open[ba])
					report_violation("READ from a closed bank");
				rd_pipe[0]  <= mem.exists(key) ? mem[key] : fill_word(key);
				rd_valid[0] <= 1'b1;
				if (addr[10])
					bank_open[ba] = 1'b0;
			end
			sdram_pkg::CMD_PALL: bank_open = 4'b0000;
			sdram_pkg::CMD_REF: begin
				if (|bank_open)
					report_violation("REF while a bank is open");
			end
			sdram_pkg::CMD_MRS: begin
				if (addr != `SDRAM_MODE_WORD)
					report_violation("MRS with a wrong mode word");
				mode_set = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

/* sim/tb_sdram_controller.sv */
`timescale 1ns/10ps
`include "sdram_params.svh"

module tb_sdram_controller;

	localparam int N_ENTRIES   = 15;
	localparam int IDLE_CYCLES = 2000;
	// One write from the sampling edge back to IDLE
	localparam int WRITE_SEQ   = 10;
	localparam int REF_MIN_GAP = int'(`SDRAM_REFRESH_INTERVAL);
	localparam int REF_MAX_GAP = REF_MIN_GAP + WRITE_SEQ + 1;
	// Power-up, table and the idle stretch
	localparam int TIMEOUT = int'(`SDRAM_INIT_WAIT) + 200 + 30 * N_ENTRIES + IDLE_CYCLES;

	logic                  sys_clk = 1'b0;
	logic                  rstn;
	sdram_pkg::avl_addr_t  avl_addr;
	sdram_pkg::byte_en_t   avl_byte_en;
	logic                  avl_write;
	logic                  avl_read;
	sdram_pkg::data_t      avl_wrdata;
	sdram_pkg::data_t      avl_rddata;
	logic                  avl_req_wait;
	logic                  csn;
	logic                  rasn;
	logic                  casn;
	logic                  wen;
	sdram_pkg::bank_t      ba;
	sdram_pkg::row_t       addr;
	sdram_pkg::byte_en_t   dqm;
	sdram_pkg::data_t      dq_out;
	logic                  dq_oe;
	sdram_pkg::data_t      dq_in;
	sdram_pkg::sdram_cmd_t pin_cmd;
	int                    model_errs;

	// Stimulus table with expected latency
	logic                 tbl_write  [N_ENTRIES];
	sdram_pkg::avl_addr_t tbl_addr   [N_ENTRIES];
	sdram_pkg::byte_en_t  tbl_be     [N_ENTRIES];
	sdram_pkg::data_t     tbl_data   [N_ENTRIES];
	int                   tbl_cycles [N_ENTRIES];
	sdram_pkg::data_t     ref_mem [sdram_pkg::avl_addr_t];

	int errors = 0;
	int cyc = 0;
	// Pin monitor bookkeeping
	int last_ref_cyc = 0;
	int prev_ref_cyc = -1;
	int init_pall = 0;
	int init_refs = 0;
	int mrs_count = 0;
	int post_refs = 0;

	always #10 sys_clk = ~sys_clk;

	always @(posedge sys_clk)
		cyc <= cyc + 1;

	sdram_controller DUT (
		.sys_clk(sys_clk), .rstn(rstn),
		.avl_addr(avl_addr), .avl_byte_en(avl_byte_en), .avl_write(avl_write),
		.avl_read(avl_read), .avl_wrdata(avl_wrdata), .avl_rddata(avl_rddata),
		.avl_req_wait(avl_req_wait), .csn(csn), .rasn(rasn), .casn(casn), .wen(wen),
		.ba(ba), .addr(addr), .dqm(dqm), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
	);

	sdram_model model (
		.sys_clk(sys_clk), .csn(csn), .rasn(rasn), .casn(casn), .wen(wen),
		.ba(ba), .addr(addr), .dqm(dqm), .dq_out(dq_out), .dq_oe(dq_oe),
		.dq_in(dq_in), .err_count(model_errs)
	);

	assign pin_cmd = sdram_pkg::sdram_cmd_t'({csn, rasn, casn, wen});

	task automatic check_data(input string what, input sdram_pkg::data_t got,
			input sdram_pkg::data_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Range compare where lo == hi asks for an exact count
	task automatic check_count(input string what, input int got, input int lo, input int hi);
		if (got < lo || got > hi) begin
			errors++;
			$display("FAIL %0t: %s is %0d, expected %0d..%0d", $time, what, got, lo, hi);
		end
	endtask

	task automatic set_entry(input int idx, input logic wr, input sdram_pkg::bank_t b,
			input sdram_pkg::row_t r, input sdram_pkg::col_t c, input sdram_pkg::byte_en_t be);
		tbl_write[idx]  = wr;
		tbl_addr[idx]   = {b, r, c};
		tbl_be[idx]     = be;
		tbl_data[idx]   = sdram_pkg::data_t'($urandom);
		tbl_cycles[idx] = wr ? 9 : 7;
	endtask

	task automatic load_table();
		set_entry(0, 1'b1, 2'd0, 12'h001, 8'h05, 2'b11);
		set_entry(1, 1'b1, 2'd1, 12'h7a3, 8'hff, 2'b11);
		set_entry(2, 1'b1, 2'd2, 12'hfff, 8'h00, 2'b11);
		set_entry(3, 1'b1, 2'd3, 12'h123, 8'h80, 2'b11);
		set_entry(4, 1'b0, 2'd0, 12'h001, 8'h05, 2'b11);
		set_entry(5, 1'b0, 2'd1, 12'h7a3, 8'hff, 2'b11);
		set_entry(6, 1'b0, 2'd2, 12'hfff, 8'h00, 2'b11);
		set_entry(7, 1'b0, 2'd3, 12'h123, 8'h80, 2'b11);
		// Single byte lanes
		set_entry(8, 1'b1, 2'd1, 12'h7a3, 8'hff, 2'b01);
		set_entry(9, 1'b0, 2'd1, 12'h7a3, 8'hff, 2'b11);
		set_entry(10, 1'b1, 2'd3, 12'h123, 8'h80, 2'b10);
		set_entry(11, 1'b0, 2'd3, 12'h123, 8'h80, 2'b11);
		// Other row in bank 0 and a reread of the first row
		set_entry(12, 1'b1, 2'd0, 12'h800, 8'h3c, 2'b11);
		set_entry(13, 1'b0, 2'd0, 12'h001, 8'h05, 2'b11);
		set_entry(14, 1'b0, 2'd0, 12'h800, 8'h3c, 2'b11);
	endtask

	// Holds the request until wait drops and counts the waiting cycles
	task automatic bus_access(input int idx, output sdram_pkg::data_t rdata, output int waited);
		waited = 0;
		@(posedge sys_clk);
		#2;
		avl_addr    = tbl_addr[idx];
		avl_byte_en = tbl_be[idx];
		avl_wrdata  = tbl_data[idx];
		avl_write   = tbl_write[idx];
		avl_read    = !tbl_write[idx];
		@(negedge sys_clk);
		while (avl_req_wait) begin
			waited++;
			@(negedge sys_clk);
		end
		rdata = avl_rddata;
		@(posedge sys_clk);
		#2;
		avl_write = 1'b0;
		avl_read  = 1'b0;
	endtask

	// Pins and wait sampled mid-cycle
	always @(negedge sys_clk) begin
		if (rstn) begin
			if (!avl_req_wait && !(avl_write ^ avl_read)) begin
				errors++;
				$display("FAIL %0t: avl_req_wait low with no request held", $time);
			end
			if (!avl_req_wait && mrs_count == 0) begin
				errors++;
				$display("FAIL %0t: avl_req_wait low during power-up", $time);
			end
			case (pin_cmd)
				sdram_pkg::CMD_PALL: begin
					if (mrs_count == 0)
						init_pall++;
					check_count("REF before PALL", init_refs, 0, 0);
				end
				sdram_pkg::CMD_REF: begin
					if (mrs_count == 0) begin
						init_refs++;
					end else begin
						if (prev_ref_cyc >= 0)
							check_count("cycles between refreshes", cyc - prev_ref_cyc,
								REF_MIN_GAP, REF_MAX_GAP);
						prev_ref_cyc = cyc;
						post_refs++;
					end
					last_ref_cyc = cyc;
				end
				sdram_pkg::CMD_MRS: begin
					mrs_count++;
					check_count("PALL before MRS", init_pall, 1, 1);
					check_count("REF before MRS", init_refs, 8, 8);
					check_count("MRS address", int'(addr), int'(`SDRAM_MODE_WORD),
						int'(`SDRAM_MODE_WORD));
				end
				sdram_pkg::CMD_ACT: check_count("MRS before ACT", mrs_count, 1, 1);
				default: ;
			endcase
		end
	end

	initial begin
		int                   start_cyc;
		int                   waited;
		int                   refs_before;
		sdram_pkg::data_t     rdata;
		sdram_pkg::data_t     merged;
		sdram_pkg::avl_addr_t a;
		void'($urandom(32'h746d));
		rstn        = 1'b0;
		avl_addr    = '0;
		avl_byte_en = '0;
		avl_write   = 1'b0;
		avl_read    = 1'b0;
		avl_wrdata  = '0;
		load_table();
		repeat (3) @(posedge sys_clk);
		#2 rstn = 1'b1;
		// First entry is held through power-up
		for (int i = 0; i < N_ENTRIES; i++) begin
			start_cyc = cyc;
			bus_access(i, rdata, waited);
			// Exact latency only with no refresh near the request
			if (last_ref_cyc + 10 < start_cyc)
				check_count("wait cycles", waited, tbl_cycles[i], tbl_cycles[i]);
			else
				check_count("wait cycles", waited, tbl_cycles[i], TIMEOUT);
			a = tbl_addr[i];
			if (tbl_write[i]) begin
				merged = ref_mem.exists(a) ? ref_mem[a] : 16'h0000;
				if (tbl_be[i][0])
					merged[7:0] = tbl_data[i][7:0];
				if (tbl_be[i][1])
					merged[15:8] = tbl_data[i][15:8];
				ref_mem[a] = merged;
			end else begin
				check_data("read data", rdata, ref_mem[a]);
			end
		end
		refs_before = post_refs;
		repeat (IDLE_CYCLES) @(posedge sys_clk);
		check_count("refreshes in idle stretch", post_refs - refs_before, 5, 6);
		check_count("mode register sets", mrs_count, 1, 1);
		check_count("model protocol errors", model_errs, 0, 0);
		$display("Done: %0d accesses, %0d refreshes after init, %0d protocol errors, %0d errors",
			N_ENTRIES, post_refs, model_errs, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		wait (cyc >= TIMEOUT);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* files.f */
+incdir+hw
hw/sdram_pkg.sv
hw/sdram_init_seq.sv
hw/sdram_refresh_timer.sv
hw/sdram_access_ctrl.sv
hw/sdram_controller.sv
sim/sdram_model.sv
sim/tb_sdram_controller.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module tb_sdram_controller -f files.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx '>>> PASS'
